/* design/mips_pkg.sv */
`default_nettype none

package mips_pkg;

  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_j     = 6'h02,
    op_jal   = 6'h03,
    op_beq   = 6'h04,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_ori   = 6'h0d,
    op_lui   = 6'h0f,
    op_lw    = 6'h23,
    op_sw    = 6'h2b,
    op_halt  = 6'h3f   // custom stop opcode
  } opcode_e;

  typedef enum logic [5:0] {
    fn_sll = 6'h00,
    fn_jr  = 6'h08,
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll, alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_lui} wb_src_e;

  typedef enum logic [1:0] {fwd_none, fwd_from_mem_wb, fwd_from_ex_mem} fwd_sel_e;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } if_id_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;       // already extended, lui pre-shifted
    alu_op_e     alu_op;
    logic        alu_src_imm;
    logic        link;      // jal writes pc+4
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    wb_src_e     wb_src;
    logic        is_branch;
    logic        branch_ne;
    logic        is_jr;
    logic        is_halt;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] alu_result;
    logic [31:0] store_data;
    logic [4:0]  dest;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    wb_src_e     wb_src;
    logic [15:0] upper_imm;
    logic        is_halt;
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] wdata;
    logic [4:0]  dest;
    logic        reg_write;
    logic        is_store;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        is_halt;
  } mem_wb_t;

  typedef struct packed {
    logic        taken;
    logic [31:0] target;
  } redirect_t;

  typedef struct packed {
    logic [7:0]  addr;      // word index into imem
    logic [31:0] data;
  } load_word_t;

  typedef struct packed {
    logic [31:0] pc;
    logic        reg_write;
    logic [4:0]  dest;
    logic [31:0] wdata;
    logic        is_store;
    logic [31:0] store_addr;
    logic [31:0] store_data;
  } retire_t;

endpackage

`default_nettype wire

/* design/core_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl
  import mips_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire load_word_t load,
  input  wire logic       load_valid,
  output logic            load_ready,
  input  wire logic       start,
  input  wire logic       halt_retired,
  output logic            imem_we,
  output logic [7:0]      imem_addr,
  output logic [31:0]     imem_wdata,
  output logic            run,
  output logic            done
);

  typedef enum logic [1:0] {st_idle, st_run, st_halted} state_e;

  state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (start) state <= st_run;
        st_run:  if (halt_retired) state <= st_halted;
        default: state <= st_halted;  // sticky until reset
      endcase
    end
  end

  assign load_ready = (state == st_idle);
  assign imem_we    = load_valid && load_ready;
  assign imem_addr  = load.addr;
  assign imem_wdata = load.data;
  assign run        = (state == st_run);
  assign done       = (state == st_halted);

  // no program word may be offered once the core has left idle
  assert property (@(posedge clk) disable iff (!rst_n)
    (run || done) |-> !load_valid)
    else $error("program load offered outside idle");

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
  import mips_pkg::*;
#(
  parameter int imem_words = 256
)
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        run,
  input  wire logic        stall,
  input  wire redirect_t   redirect_id,
  input  wire redirect_t   redirect_ex,
  input  wire logic        imem_we,
  input  wire logic [7:0]  imem_addr,
  input  wire logic [31:0] imem_wdata,
  output if_id_t           if_id
);

  localparam int iaw = $clog2(imem_words);

  logic [31:0] imem [imem_words];
  logic [31:0] pc;
  logic [31:0] pc_next;
  logic        redirect;

  assign redirect = redirect_ex.taken || redirect_id.taken;

  // older redirect wins
  always_comb begin
    if (redirect_ex.taken) pc_next = redirect_ex.target;
    else if (redirect_id.taken) pc_next = redirect_id.target;
    else if (stall) pc_next = pc;
    else pc_next = pc + 32'd4;
  end

  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr] <= imem_wdata;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc          <= '0;
      if_id.valid <= 1'b0;
    end else if (run) begin
      pc <= pc_next;
      if (redirect || !stall) begin
        if_id.valid <= !redirect;  // wrong-path slot becomes a bubble
        if_id.pc    <= pc;
        if_id.instr <= imem[pc[iaw+1:2]];
      end
    end else begin
      if_id.valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic [4:0]  rs,
  input  wire logic [4:0]  rt,
  output logic [31:0]      rd_a,
  output logic [31:0]      rd_b,
  input  wire logic        we,
  input  wire logic [4:0]  waddr,
  input  wire logic [31:0] wdata
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // writeback in the same cycle is visible to decode
  function automatic logic [31:0] read_port(input logic [4:0] r);
    if (r == 5'd0) return '0;
    if (we && waddr == r) return wdata;
    return regs[r];
  endfunction

  always_comb begin
    rd_a = read_port(rs);
    rd_b = read_port(rt);
  end

endmodule

`default_nettype wire

/* design/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit
  import mips_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire if_id_t      if_id,
  input  wire logic        stall,
  input  wire logic        flush,
  input  wire logic [31:0] rd_a,
  input  wire logic [31:0] rd_b,
  output logic [4:0]       rs,
  output logic [4:0]       rt,
  output id_ex_t           id_ex,
  output redirect_t        redirect_id
);

  opcode_e     opcode;
  funct_e      funct;
  logic [4:0]  rd;
  logic [15:0] imm16;
  logic [31:0] pc_plus4;
  id_ex_t      id_ex_d;

  assign opcode   = opcode_e'(if_id.instr[31:26]);
  assign funct    = funct_e'(if_id.instr[5:0]);
  assign rs       = if_id.instr[25:21];
  assign rt       = if_id.instr[20:16];
  assign rd       = if_id.instr[15:11];
  assign imm16    = if_id.instr[15:0];
  assign pc_plus4 = if_id.pc + 32'd4;

  always_comb begin
    id_ex_d       = '0;  // alu_add, wb_alu, no side effects
    id_ex_d.valid = if_id.valid && !stall && !flush;
    id_ex_d.pc    = if_id.pc;
    id_ex_d.rs    = rs;
    id_ex_d.rt    = rt;
    id_ex_d.a     = rd_a;
    id_ex_d.b     = rd_b;
    id_ex_d.imm   = {{16{imm16[15]}}, imm16};  // shamt sits in imm[10:6] for sll
    case (opcode)
      op_rtype: begin
        id_ex_d.dest      = rd;
        id_ex_d.reg_write = 1'b1;
        case (funct)
          fn_add: id_ex_d.alu_op = alu_add;
          fn_sub: id_ex_d.alu_op = alu_sub;
          fn_and: id_ex_d.alu_op = alu_and;
          fn_or:  id_ex_d.alu_op = alu_or;
          fn_slt: id_ex_d.alu_op = alu_slt;
          fn_sll: id_ex_d.alu_op = alu_sll;
          fn_jr: begin
            id_ex_d.is_jr     = 1'b1;
            id_ex_d.reg_write = 1'b0;
          end
          default: id_ex_d.reg_write = 1'b0;
        endcase
      end
      op_addi: begin
        id_ex_d.dest        = rt;
        id_ex_d.reg_write   = 1'b1;
        id_ex_d.alu_src_imm = 1'b1;
      end
      op_ori: begin
        id_ex_d.dest        = rt;
        id_ex_d.reg_write   = 1'b1;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.alu_op      = alu_or;
        id_ex_d.imm         = {16'h0, imm16};  // logical op, zero extend
      end
      op_lui: begin
        id_ex_d.dest        = rt;
        id_ex_d.reg_write   = 1'b1;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.alu_op      = alu_pass_b;  // keeps EX/MEM forwarding correct
        id_ex_d.imm         = {imm16, 16'h0};
        id_ex_d.wb_src      = wb_lui;
      end
      op_lw: begin
        id_ex_d.dest        = rt;
        id_ex_d.reg_write   = 1'b1;
        id_ex_d.mem_read    = 1'b1;
        id_ex_d.alu_src_imm = 1'b1;
        id_ex_d.wb_src      = wb_mem;
      end
      op_sw: begin
        id_ex_d.mem_write   = 1'b1;
        id_ex_d.alu_src_imm = 1'b1;
      end
      op_beq: id_ex_d.is_branch = 1'b1;
      op_bne: begin
        id_ex_d.is_branch = 1'b1;
        id_ex_d.branch_ne = 1'b1;
      end
      op_jal: begin
        id_ex_d.dest      = 5'd31;
        id_ex_d.reg_write = 1'b1;
        id_ex_d.link      = 1'b1;
      end
      op_halt: id_ex_d.is_halt = 1'b1;
      default: ;  // j and unknown opcodes carry no side effects
    endcase
  end

  assign redirect_id = '{
    taken:  if_id.valid && !stall && !flush && (opcode == op_j || opcode == op_jal),
    target: {pc_plus4[31:28], if_id.instr[25:0], 2'b00}
  };

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
  import mips_pkg::*;
(
  input  wire logic [4:0] if_id_rs,
  input  wire logic [4:0] if_id_rt,
  input  wire id_ex_t     id_ex,
  input  wire ex_mem_t    ex_mem,
  input  wire mem_wb_t    mem_wb,
  output fwd_sel_e        fwd_a,
  output fwd_sel_e        fwd_b,
  output logic            stall
);

  // youngest producer wins, r0 is never forwarded
  function automatic fwd_sel_e pick(input logic [4:0] src, input ex_mem_t em,
                                    input mem_wb_t mw);
    if (src == 5'd0) return fwd_none;
    if (em.valid && em.reg_write && em.dest == src) return fwd_from_ex_mem;
    if (mw.valid && mw.reg_write && mw.dest == src) return fwd_from_mem_wb;
    return fwd_none;
  endfunction

  assign fwd_a = pick(id_ex.rs, ex_mem, mem_wb);
  assign fwd_b = pick(id_ex.rt, ex_mem, mem_wb);

  // load data only exists after MEM, so hold the consumer one cycle
  assign stall = id_ex.valid && id_ex.mem_read && id_ex.dest != 5'd0 &&
                 (id_ex.dest == if_id_rs || id_ex.dest == if_id_rt);

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit
  import mips_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire id_ex_t      id_ex,
  input  wire fwd_sel_e    fwd_a,
  input  wire fwd_sel_e    fwd_b,
  input  wire logic [31:0] fwd_ex_mem,
  input  wire logic [31:0] fwd_mem_wb,
  output ex_mem_t          ex_mem,
  output redirect_t        redirect_ex
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_b;
  logic [31:0] alu_y;
  logic [31:0] pc_plus4;
  logic        br_taken;
  ex_mem_t     ex_mem_d;

  function automatic logic [31:0] fwd_mux(input fwd_sel_e sel, input logic [31:0] reg_val,
                                          input logic [31:0] em, input logic [31:0] mw);
    case (sel)
      fwd_from_ex_mem: return em;
      fwd_from_mem_wb: return mw;
      default:         return reg_val;
    endcase
  endfunction

  assign op_a     = fwd_mux(fwd_a, id_ex.a, fwd_ex_mem, fwd_mem_wb);
  assign op_b     = fwd_mux(fwd_b, id_ex.b, fwd_ex_mem, fwd_mem_wb);
  assign alu_b    = id_ex.alu_src_imm ? id_ex.imm : op_b;
  assign pc_plus4 = id_ex.pc + 32'd4;

  always_comb begin
    case (id_ex.alu_op)
      alu_sub:    alu_y = op_a - alu_b;
      alu_and:    alu_y = op_a & alu_b;
      alu_or:     alu_y = op_a | alu_b;
      alu_slt:    alu_y = {31'd0, $signed(op_a) < $signed(alu_b)};
      alu_sll:    alu_y = alu_b << id_ex.imm[10:6];
      alu_pass_b: alu_y = alu_b;
      default:    alu_y = op_a + alu_b;
    endcase
  end

  assign br_taken = id_ex.is_branch && ((op_a == op_b) != id_ex.branch_ne);

  assign redirect_ex = '{
    taken:  id_ex.valid && (br_taken || id_ex.is_jr),
    target: id_ex.is_jr ? op_a : pc_plus4 + {id_ex.imm[29:0], 2'b00}
  };

  always_comb begin
    ex_mem_d.valid      = id_ex.valid;
    ex_mem_d.pc         = id_ex.pc;
    ex_mem_d.alu_result = id_ex.link ? pc_plus4 : alu_y;  // jal link address
    ex_mem_d.store_data = op_b;
    ex_mem_d.dest       = id_ex.dest;
    ex_mem_d.reg_write  = id_ex.reg_write;
    ex_mem_d.mem_read   = id_ex.mem_read;
    ex_mem_d.mem_write  = id_ex.mem_write;
    ex_mem_d.wb_src     = id_ex.wb_src;
    ex_mem_d.upper_imm  = id_ex.imm[31:16];
    ex_mem_d.is_halt    = id_ex.is_halt;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem <= ex_mem_d;
    end
  end

  // the hazard unit must never route a zero-register result into operand a
  assert property (@(posedge clk) disable iff (!rst_n)
    id_ex.valid && fwd_a == fwd_from_ex_mem |-> ex_mem.valid && ex_mem.dest != 5'd0)
    else $error("forward from EX/MEM with destination r0");

endmodule

`default_nettype wire

/* design/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem
  import mips_pkg::*;
#(
  parameter int dmem_words = 256
)
(
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire ex_mem_t ex_mem,
  output mem_wb_t      mem_wb
);

  localparam int daw = $clog2(dmem_words);

  logic [31:0]    mem [dmem_words];
  logic [daw-1:0] widx;
  logic [31:0]    rdata;
  logic [31:0]    wdata;
  mem_wb_t        mem_wb_d;

  assign widx  = ex_mem.alu_result[daw+1:2];  // word addressed
  assign rdata = mem[widx];

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write) mem[widx] <= ex_mem.store_data;
  end

  always_comb begin
    case (ex_mem.wb_src)
      wb_mem:  wdata = rdata;
      wb_lui:  wdata = {ex_mem.upper_imm, 16'h0};
      default: wdata = ex_mem.alu_result;
    endcase
  end

  assign mem_wb_d = '{
    valid:      ex_mem.valid,
    pc:         ex_mem.pc,
    wdata:      wdata,
    dest:       ex_mem.dest,
    reg_write:  ex_mem.reg_write,
    is_store:   ex_mem.mem_write,
    store_addr: ex_mem.alu_result,
    store_data: ex_mem.store_data,
    is_halt:    ex_mem.is_halt
  };

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb <= mem_wb_d;
    end
  end

  // no byte lanes, so every address built in EX has to be word aligned
  assert property (@(posedge clk) disable iff (!rst_n)
    ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write) |-> ex_mem.alu_result[1:0] == 2'b00)
    else $error("misaligned data access");

endmodule

`default_nettype wire

/* design/mips_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_top
  import mips_pkg::*;
#(
  parameter int imem_words = 256,
  parameter int dmem_words = 256
)
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire load_word_t load,
  input  wire logic       load_valid,
  output logic            load_ready,
  input  wire logic       start,
  output logic            running,
  output logic            done,
  output retire_t         retire,
  output logic            retire_valid
);

  logic        run;
  logic        imem_we;
  logic [7:0]  imem_addr;
  logic [31:0] imem_wdata;
  logic        stall;
  logic        halt_retired;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [31:0] rd_a;
  logic [31:0] rd_b;
  if_id_t      if_id;
  id_ex_t      id_ex;
  ex_mem_t     ex_mem;
  mem_wb_t     mem_wb;
  redirect_t   redirect_id;
  redirect_t   redirect_ex;
  fwd_sel_e    fwd_a;
  fwd_sel_e    fwd_b;

  assign halt_retired = mem_wb.valid && mem_wb.is_halt;
  assign running      = run;
  assign retire_valid = mem_wb.valid && run;  // drained slots after halt stay silent

  assign retire = '{
    pc:         mem_wb.pc,
    reg_write:  mem_wb.reg_write,
    dest:       mem_wb.dest,
    wdata:      mem_wb.wdata,
    is_store:   mem_wb.is_store,
    store_addr: mem_wb.store_addr,
    store_data: mem_wb.store_data
  };

  core_ctrl i_core_ctrl (
    .clk, .rst_n, .load, .load_valid, .load_ready, .start, .halt_retired,
    .imem_we, .imem_addr, .imem_wdata, .run, .done
  );

  fetch_stage #(.imem_words(imem_words)) i_fetch (
    .clk, .rst_n, .run, .stall, .redirect_id, .redirect_ex,
    .imem_we, .imem_addr, .imem_wdata, .if_id
  );

  reg_file i_reg_file (
    .clk, .rst_n, .rs, .rt, .rd_a, .rd_b,
    .we    (mem_wb.valid && mem_wb.reg_write),
    .waddr (mem_wb.dest),
    .wdata (mem_wb.wdata)
  );

  decode_unit i_decode (
    .clk, .rst_n, .if_id, .stall,
    .flush (redirect_ex.taken),
    .rd_a, .rd_b, .rs, .rt, .id_ex, .redirect_id
  );

  hazard_unit i_hazard (
    .if_id_rs (rs),
    .if_id_rt (rt),
    .id_ex, .ex_mem, .mem_wb, .fwd_a, .fwd_b, .stall
  );

  exec_unit i_exec (
    .clk, .rst_n, .id_ex, .fwd_a, .fwd_b,
    .fwd_ex_mem (ex_mem.alu_result),
    .fwd_mem_wb (mem_wb.wdata),
    .ex_mem, .redirect_ex
  );

  data_mem #(.dmem_words(dmem_words)) i_data_mem (
    .clk, .rst_n, .ex_mem, .mem_wb
  );

endmodule

`default_nettype wire

/* sim/mips_ref_model.svh */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// galois lfsr, one step per bit handed out
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
  end
  return v;
endfunction

function automatic logic [31:0] r_word(input funct_e fn, input logic [4:0] rd,
                                       input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] shamt);
  return {6'h00, rs, rt, rd, shamt, fn};
endfunction

function automatic logic [31:0] i_word(input opcode_e op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] j_word(input opcode_e op, input int idx);
  return {op, 26'(idx)};  // word index of the target
endfunction

localparam logic [31:0] halt_word = {op_halt, 26'd0};

task automatic emit(input logic [31:0] w);
  prog[prog_len] = w;
  prog_len++;
endtask

// unused words become halts so nothing past the end runs wild
task automatic pad_program();
  for (int i = prog_len; i < 256; i++) prog[i] = halt_word;
endtask

task automatic build_random();
  int          kind;
  logic [4:0]  d;
  logic [4:0]  s;
  logic [4:0]  t;
  logic [15:0] imm;
  prog_len = 0;
  for (int k = 1; k < 8; k++) emit(i_word(op_ori, 5'd0, 5'(k), 16'(rand_bits(16))));
  for (int k = 0; k < 8; k++) emit(i_word(op_sw, 5'd0, 5'(k), 16'(k * 4)));  // words 0..7 known
  for (int n = 0; n < 40; n++) begin
    kind = int'(rand_bits(4));
    d    = 5'(rand_bits(3));  // small register set keeps hazards dense
    s    = 5'(rand_bits(3));
    t    = 5'(rand_bits(3));
    imm  = 16'(rand_bits(16));
    case (kind)
      0, 1:    emit(r_word(fn_add, d, s, t, 5'd0));
      2:       emit(r_word(fn_sub, d, s, t, 5'd0));
      3:       emit(r_word(fn_and, d, s, t, 5'd0));
      4:       emit(r_word(fn_or, d, s, t, 5'd0));
      5:       emit(r_word(fn_slt, d, s, t, 5'd0));
      6:       emit(r_word(fn_sll, d, 5'd0, t, imm[4:0]));
      7, 8:    emit(i_word(op_addi, s, d, imm));
      9:       emit(i_word(op_ori, s, d, imm));
      10:      emit(i_word(op_lui, 5'd0, d, imm));
      11, 12:  emit(i_word(op_lw, 5'd0, d, {11'd0, imm[2:0], 2'b00}));
      13:      emit(i_word(op_sw, 5'd0, t, {11'd0, imm[2:0], 2'b00}));
      14:      emit(i_word(op_beq, s, t, 16'd1));  // forward skip of one
      default: emit(i_word(op_bne, s, t, 16'd1));
    endcase
  end
  emit(halt_word);
endtask

// instruction-set model, one retire record per executed instruction
function automatic void ref_run();
  logic [31:0] r [32];
  logic [31:0] dm [256];
  logic [31:0] pc;
  logic [31:0] npc;
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] simm;
  logic [31:0] addr;
  retire_t     rec;
  for (int i = 0; i < 32; i++) r[i] = '0;
  for (int i = 0; i < 256; i++) dm[i] = '0;
  exp_q.delete();
  pc = '0;
  for (int step = 0; step < 4096; step++) begin
    ins    = prog[pc[9:2]];
    a      = r[ins[25:21]];
    b      = r[ins[20:16]];
    simm   = {{16{ins[15]}}, ins[15:0]};
    addr   = a + simm;
    npc    = pc + 32'd4;
    rec    = '0;
    rec.pc = pc;
    case (ins[31:26])
      op_rtype: begin
        rec.reg_write = 1'b1;
        rec.dest      = ins[15:11];
        case (ins[5:0])
          fn_add:  rec.wdata = a + b;
          fn_sub:  rec.wdata = a - b;
          fn_and:  rec.wdata = a & b;
          fn_or:   rec.wdata = a | b;
          fn_slt:  rec.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fn_sll:  rec.wdata = b << ins[10:6];
          fn_jr: begin
            rec.reg_write = 1'b0;
            npc           = a;
          end
          default: rec.reg_write = 1'b0;
        endcase
      end
      op_addi, op_ori, op_lui, op_lw: begin
        rec.reg_write = 1'b1;
        rec.dest      = ins[20:16];
        if (ins[31:26] == op_addi) rec.wdata = addr;
        else if (ins[31:26] == op_ori) rec.wdata = a | {16'h0, ins[15:0]};
        else if (ins[31:26] == op_lui) rec.wdata = {ins[15:0], 16'h0};
        else rec.wdata = dm[addr[9:2]];
      end
      op_sw: begin
        rec.is_store   = 1'b1;
        rec.store_addr = addr;
        rec.store_data = b;
        dm[addr[9:2]]  = b;
      end
      op_beq: if (a == b) npc = npc + {simm[29:0], 2'b00};
      op_bne: if (a != b) npc = npc + {simm[29:0], 2'b00};
      op_j:   npc = {npc[31:28], ins[25:0], 2'b00};
      op_jal: begin
        rec.reg_write = 1'b1;
        rec.dest      = 5'd31;
        rec.wdata     = pc + 32'd4;
        npc           = {npc[31:28], ins[25:0], 2'b00};
      end
      op_halt: begin
        exp_q.push_back(rec);
        return;
      end
      default: ;
    endcase
    exp_q.push_back(rec);
    if (rec.reg_write && rec.dest != 5'd0) r[rec.dest] = rec.wdata;
    pc = npc;
  end
endfunction

`endif

/* sim/tb_mips_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipe
  import mips_pkg::*;
;

  logic        clk;
  logic        rst_n;
  load_word_t  load;
  logic        load_valid;
  logic        load_ready;
  logic        start;
  logic        running;
  logic        done;
  retire_t     retire;
  logic        retire_valid;

  logic [31:0] prog [256];
  int          prog_len;
  retire_t     exp_q [$];
  logic [15:0] lfsr_state;
  string       test_name;
  logic        checking;

  `include "mips_ref_model.svh"

  mips_pipe_top #(.imem_words(256), .dmem_words(256)) i_dut (
    .clk, .rst_n, .load, .load_valid, .load_ready, .start,
    .running, .done, .retire, .retire_valid
  );

  always #20 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_retire(input retire_t exp, input retire_t act);
    logic ok;
    ok = (exp.pc === act.pc) && (exp.reg_write === act.reg_write) &&
         (exp.is_store === act.is_store);
    // payload fields only mean something for writers and stores
    if (exp.reg_write) ok = ok && (exp.dest === act.dest) && (exp.wdata === act.wdata);
    if (exp.is_store) begin
      ok = ok && (exp.store_addr === act.store_addr) && (exp.store_data === act.store_data);
    end
    if (!ok) begin
      report_failure($sformatf("CHECK FAILED %s: retire expected %h actual %h",
                               test_name, exp, act));
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("CHECK FAILED %s (%s): expected %b actual %b",
                               test_name, what, exp, act));
    end
  endtask

  // retire monitor samples mid-cycle
  always @(negedge clk) begin
    if (checking && rst_n) begin
      if (retire_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          report_failure($sformatf("%s: unexpected retire at pc %h after the program ended",
                                   test_name, retire.pc));
        end else begin
          compare_retire(exp_q.pop_front(), retire);
        end
      end
      if (done === 1'b1 && exp_q.size() != 0) begin
        report_failure($sformatf("%s: done rose with %0d instructions not yet retired",
                                 test_name, exp_q.size()));
      end
      if (running === 1'b1) compare_flag("load_ready while running", 1'b0, load_ready);
    end
  end

  task automatic run_program(input string name);
    int cycles;
    test_name = name;
    pad_program();
    ref_run();
    @(posedge clk);
    rst_n      <= 1'b0;
    load_valid <= 1'b0;
    start      <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_flag("load_ready after reset", 1'b1, load_ready);
    compare_flag("running after reset", 1'b0, running);
    compare_flag("done after reset", 1'b0, done);
    compare_flag("retire_valid after reset", 1'b0, retire_valid);
    for (int w = 0; w < 256; w++) begin
      @(posedge clk);
      load       <= '{addr: 8'(w), data: prog[w]};
      load_valid <= 1'b1;
      cycles = 0;
      @(negedge clk);
      while (load_ready !== 1'b1) begin
        cycles++;
        if (cycles > 20) begin
          report_failure($sformatf("%s: program word %0d never accepted", name, w));
        end
        @(negedge clk);
      end
    end
    @(posedge clk);
    load_valid <= 1'b0;
    start      <= 1'b1;
    checking = 1'b1;
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (running !== 1'b1) begin
      cycles++;
      if (cycles > 10) report_failure($sformatf("%s: core did not start running", name));
      @(negedge clk);
    end
    cycles = 0;
    while (done !== 1'b1) begin
      cycles++;
      if (cycles > 3000) report_failure($sformatf("%s: halt never retired", name));
      @(negedge clk);
    end
    compare_flag("running after halt", 1'b0, running);
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%s: %0d expected retires missing", name, exp_q.size()));
    end
    repeat (8) @(negedge clk);  // monitor flags any late pulse
    compare_flag("done holds", 1'b1, done);
    checking = 1'b0;
  endtask

  task automatic build_alu_chain();
    prog_len = 0;
    emit(i_word(op_ori, 5'd0, 5'd1, 16'd5));
    emit(i_word(op_ori, 5'd0, 5'd2, 16'd3));
    emit(r_word(fn_add, 5'd3, 5'd1, 5'd2, 5'd0));   // ex/mem and mem/wb forwards
    emit(r_word(fn_sub, 5'd4, 5'd3, 5'd1, 5'd0));
    emit(r_word(fn_and, 5'd5, 5'd4, 5'd3, 5'd0));
    emit(r_word(fn_or, 5'd6, 5'd5, 5'd1, 5'd0));
    emit(r_word(fn_slt, 5'd7, 5'd2, 5'd1, 5'd0));
    emit(r_word(fn_slt, 5'd8, 5'd1, 5'd2, 5'd0));
    emit(r_word(fn_sll, 5'd9, 5'd0, 5'd3, 5'd4));
    emit(i_word(op_addi, 5'd9, 5'd10, 16'hfff9));  // -7
    emit(r_word(fn_add, 5'd11, 5'd10, 5'd3, 5'd0));
    emit(i_word(op_addi, 5'd0, 5'd12, 16'hffff));
    emit(r_word(fn_slt, 5'd13, 5'd12, 5'd1, 5'd0)); // signed compare
    emit(halt_word);
  endtask

  task automatic build_mem_test();
    prog_len = 0;
    emit(i_word(op_ori, 5'd0, 5'd1, 16'h1234));
    emit(i_word(op_ori, 5'd0, 5'd2, 16'd8));
    emit(i_word(op_sw, 5'd2, 5'd1, 16'd4));
    emit(i_word(op_lw, 5'd2, 5'd3, 16'd4));
    emit(r_word(fn_add, 5'd4, 5'd3, 5'd3, 5'd0));  // load-use stall
    emit(i_word(op_sw, 5'd0, 5'd4, 16'd0));
    emit(i_word(op_lw, 5'd0, 5'd5, 16'd0));
    emit(i_word(op_bne, 5'd5, 5'd4, 16'd1));       // stall into a branch
    emit(i_word(op_lw, 5'd0, 5'd6, 16'd12));
    emit(i_word(op_sw, 5'd2, 5'd6, 16'd16));
    emit(halt_word);
  endtask

  task automatic build_control_flow();
    prog_len = 0;
    emit(i_word(op_ori, 5'd0, 5'd1, 16'd1));       // 0
    emit(i_word(op_ori, 5'd0, 5'd2, 16'd2));       // 1
    emit(i_word(op_beq, 5'd1, 5'd2, 16'd1));       // 2 not taken
    emit(i_word(op_bne, 5'd1, 5'd2, 16'd1));       // 3 taken
    emit(i_word(op_addi, 5'd0, 5'd3, 16'd99));     // 4 flushed
    emit(i_word(op_beq, 5'd1, 5'd1, 16'd1));       // 5 taken
    emit(i_word(op_addi, 5'd0, 5'd3, 16'd77));     // 6 flushed
    emit(j_word(op_jal, 11));                       // 7
    emit(i_word(op_addi, 5'd31, 5'd4, 16'd0));     // 8 return point
    emit(j_word(op_j, 13));                         // 9
    emit(i_word(op_addi, 5'd0, 5'd5, 16'd1));      // 10 flushed
    emit(i_word(op_addi, 5'd0, 5'd6, 16'd11));     // 11 subroutine
    emit(r_word(fn_jr, 5'd0, 5'd31, 5'd0, 5'd0));  // 12
    emit(halt_word);                                // 13
  endtask

  task automatic build_upper_zero();
    prog_len = 0;
    emit(i_word(op_lui, 5'd0, 5'd1, 16'hdead));
    emit(i_word(op_ori, 5'd1, 5'd1, 16'hbeef));
    emit(i_word(op_addi, 5'd1, 5'd0, 16'd5));      // r0 target still retires
    emit(r_word(fn_add, 5'd2, 5'd0, 5'd0, 5'd0));
    emit(r_word(fn_or, 5'd3, 5'd0, 5'd1, 5'd0));
    emit(i_word(op_lui, 5'd0, 5'd0, 16'h1234));
    emit(r_word(fn_add, 5'd4, 5'd0, 5'd1, 5'd0));
    emit(halt_word);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    load       = '0;
    load_valid = 1'b0;
    start      = 1'b0;
    checking   = 1'b0;
    prog_len   = 0;
    lfsr_state = 16'd4;
    build_alu_chain();
    run_program("alu_chain");
    build_mem_test();
    run_program("load_store");
    build_control_flow();
    run_program("control_flow");
    build_upper_zero();
    run_program("upper_imm_r0");
    build_random();
    run_program("random_program");
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* mips_pipe.f */
+incdir+sim
design/mips_pkg.sv
design/core_ctrl.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_unit.sv
design/hazard_unit.sv
design/exec_unit.sv
design/data_mem.sv
design/mips_pipe_top.sv
sim/tb_mips_pipe.sv

/* Bender.yml */
package:
  name: mips_pipe

sources:
  - design/mips_pkg.sv
  - design/core_ctrl.sv
  - design/fetch_stage.sv
  - design/reg_file.sv
  - design/decode_unit.sv
  - design/hazard_unit.sv
  - design/exec_unit.sv
  - design/data_mem.sv
  - design/mips_pipe_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mips_pipe.sv
